// File: flist.f
hw/ctrlPkg.sv
hw/opcodeDecoder.sv
hw/controlSequencer.sv
hw/strobeGenerator.sv
hw/controlUnit.sv
tests/controlUnitTb.sv

// File: hw/controlSequencer.sv
`default_nettype none

module controlSequencer (
    input  logic               clk,
    input  logic               reset,
    input  ctrlPkg::ctrlStateT entryState,
    output ctrlPkg::ctrlStateT state
);

    ctrlPkg::ctrlStateT nextState;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ctrlPkg::stReset;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = ctrlPkg::stReset;
        case (state)
            ctrlPkg::stReset:   nextState = ctrlPkg::fetch0;
            ctrlPkg::fetch0:    nextState = ctrlPkg::fetch1;
            ctrlPkg::fetch1:    nextState = ctrlPkg::fetch2;
            ctrlPkg::fetch2:    nextState = entryState;
            ctrlPkg::alu3:      nextState = ctrlPkg::alu4;
            ctrlPkg::alu4:      nextState = ctrlPkg::alu5;
            ctrlPkg::aluReg3:   nextState = ctrlPkg::aluReg4;
            ctrlPkg::aluReg4:   nextState = ctrlPkg::aluReg5;
            ctrlPkg::addi3:     nextState = ctrlPkg::addi4;
            ctrlPkg::addi4:     nextState = ctrlPkg::addi5;
            ctrlPkg::logicImm3: nextState = ctrlPkg::logicImm4;
            ctrlPkg::logicImm4: nextState = ctrlPkg::logicImm5;
            ctrlPkg::load3:     nextState = ctrlPkg::load4;
            ctrlPkg::load4:     nextState = ctrlPkg::load5;
            ctrlPkg::load5:     nextState = ctrlPkg::load6;
            ctrlPkg::load6:     nextState = ctrlPkg::load7;
            ctrlPkg::loadi3:    nextState = ctrlPkg::loadi4;
            ctrlPkg::loadi4:    nextState = ctrlPkg::loadi5;
            ctrlPkg::store3:    nextState = ctrlPkg::store4;
            ctrlPkg::store4:    nextState = ctrlPkg::store5;
            ctrlPkg::store5:    nextState = ctrlPkg::store6;
            ctrlPkg::store6:    nextState = ctrlPkg::store7;
            ctrlPkg::branch3:   nextState = ctrlPkg::branch4;
            ctrlPkg::branch4:   nextState = ctrlPkg::branch5;
            ctrlPkg::branch5:   nextState = ctrlPkg::branch6;
            ctrlPkg::jump3:     nextState = ctrlPkg::jump4;
            ctrlPkg::mfhi3:     nextState = ctrlPkg::mfhi4;
            ctrlPkg::mflo3:     nextState = ctrlPkg::mflo4;
            // last state of every chain
            ctrlPkg::alu5, ctrlPkg::aluReg5, ctrlPkg::addi5, ctrlPkg::logicImm5,
            ctrlPkg::load7, ctrlPkg::loadi5, ctrlPkg::store7, ctrlPkg::branch6,
            ctrlPkg::jump4, ctrlPkg::mfhi4, ctrlPkg::mflo4: begin
                nextState = ctrlPkg::fetch0;
            end
            // only reset leaves halt
            ctrlPkg::halt3:     nextState = ctrlPkg::halt3;
            default:            nextState = ctrlPkg::stReset;
        endcase
    end

    haltHolds: assert property (@(posedge clk) disable iff (reset)
        state == ctrlPkg::halt3 |=> state == ctrlPkg::halt3);

    resetToFetch: assert property (@(posedge clk) disable iff (reset)
        state == ctrlPkg::stReset |=> state == ctrlPkg::fetch0);

endmodule

`default_nettype wire

// File: hw/controlUnit.sv
`default_nettype none

module controlUnit (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [ctrlPkg::instrWidth-1:0]  IR,
    input  logic                            CONFF,
    output logic                            PCout,
    output logic                            PCin,
    output logic                            IncPC,
    output logic                            MARin,
    output logic                            MDRin,
    output logic                            MDRout,
    output logic                            IRin,
    output logic                            Yin,
    output logic                            Zin,
    output logic                            Zlowout,
    output logic                            Read,
    output logic                            Write,
    output logic                            clear,
    output logic                            run,
    output logic                            Gra,
    output logic                            Grb,
    output logic                            Grc,
    output logic                            Rin,
    output logic                            Rout,
    output logic                            BAout,
    output logic                            Cout,
    output logic                            ConIn,
    output logic                            HIout,
    output logic                            LOout,
    output logic [ctrlPkg::opcodeWidth-1:0] aluControl
);

    ctrlPkg::ctrlStateT entryState;
    ctrlPkg::ctrlStateT state;

    opcodeDecoder decoder (
        .IR         (IR),
        .entryState (entryState),
        .aluControl (aluControl)
    );

    controlSequencer sequencer (
        .clk        (clk),
        .reset      (reset),
        .entryState (entryState),
        .state      (state)
    );

    strobeGenerator strobes (
        .clk     (clk),
        .reset   (reset),
        .CONFF   (CONFF),
        .state   (state),
        .PCout   (PCout),
        .PCin    (PCin),
        .IncPC   (IncPC),
        .MARin   (MARin),
        .MDRin   (MDRin),
        .MDRout  (MDRout),
        .IRin    (IRin),
        .Yin     (Yin),
        .Zin     (Zin),
        .Zlowout (Zlowout),
        .Read    (Read),
        .Write   (Write),
        .clear   (clear),
        .run     (run),
        .Gra     (Gra),
        .Grb     (Grb),
        .Grc     (Grc),
        .Rin     (Rin),
        .Rout    (Rout),
        .BAout   (BAout),
        .Cout    (Cout),
        .ConIn   (ConIn),
        .HIout   (HIout),
        .LOout   (LOout)
    );

endmodule

`default_nettype wire

// File: hw/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    localparam int instrWidth  = 32;
    localparam int opcodeMsb   = 31;
    localparam int opcodeLsb   = 27;
    localparam int opcodeWidth = 5;
    localparam int stateWidth  = 6;

    // codes not listed here decode as nop
    typedef enum logic [opcodeWidth-1:0] {
        opLoad   = 5'd0,
        opLoadi  = 5'd1,
        opStore  = 5'd2,
        opAdd    = 5'd3,
        opSub    = 5'd4,
        opShr    = 5'd5,
        opShl    = 5'd6,
        opRor    = 5'd7,
        opRol    = 5'd8,
        opAnd    = 5'd9,
        opOr     = 5'd10,
        opAddi   = 5'd11,
        opAndi   = 5'd12,
        opOri    = 5'd13,
        opNot    = 5'd16,
        opNeg    = 5'd17,
        opBranch = 5'd18,
        opJr     = 5'd19,
        opJal    = 5'd20,
        opMfhi   = 5'd23,
        opMflo   = 5'd24,
        opNop    = 5'd25,
        opHalt   = 5'd27
    } opcodeT;

    // ALU functions forced for address and immediate work
    localparam logic [opcodeWidth-1:0] aluAddCode = opAdd;
    localparam logic [opcodeWidth-1:0] aluAndCode = opAnd;
    localparam logic [opcodeWidth-1:0] aluOrCode  = opOr;

    typedef enum logic [stateWidth-1:0] {
        stReset,
        fetch0, fetch1, fetch2,
        alu3, alu4, alu5,
        aluReg3, aluReg4, aluReg5,
        addi3, addi4, addi5,
        logicImm3, logicImm4, logicImm5,
        load3, load4, load5, load6, load7,
        loadi3, loadi4, loadi5,
        store3, store4, store5, store6, store7,
        branch3, branch4, branch5, branch6,
        jump3, jump4,
        mfhi3, mfhi4,
        mflo3, mflo4,
        halt3
    } ctrlStateT;

endpackage

`default_nettype wire

// File: hw/opcodeDecoder.sv
`default_nettype none

module opcodeDecoder (
    input  logic [ctrlPkg::instrWidth-1:0]  IR,
    output ctrlPkg::ctrlStateT              entryState,
    output logic [ctrlPkg::opcodeWidth-1:0] aluControl
);

    ctrlPkg::opcodeT opcode;

    always_comb begin
        opcode = ctrlPkg::opcodeT'(IR[ctrlPkg::opcodeMsb:ctrlPkg::opcodeLsb]);
        entryState = ctrlPkg::fetch0;
        aluControl = opcode;
        case (opcode)
            ctrlPkg::opLoad: begin
                entryState = ctrlPkg::load3;
                aluControl = ctrlPkg::aluAddCode;
            end
            ctrlPkg::opLoadi: begin
                entryState = ctrlPkg::loadi3;
                aluControl = ctrlPkg::aluAddCode;
            end
            ctrlPkg::opStore: begin
                entryState = ctrlPkg::store3;
                aluControl = ctrlPkg::aluAddCode;
            end
            ctrlPkg::opAdd, ctrlPkg::opSub, ctrlPkg::opShr, ctrlPkg::opShl,
            ctrlPkg::opRor, ctrlPkg::opRol, ctrlPkg::opAnd, ctrlPkg::opOr: begin
                entryState = ctrlPkg::alu3;
            end
            ctrlPkg::opAddi: begin
                entryState = ctrlPkg::addi3;
                aluControl = ctrlPkg::aluAddCode;
            end
            ctrlPkg::opAndi: begin
                entryState = ctrlPkg::logicImm3;
                aluControl = ctrlPkg::aluAndCode;
            end
            ctrlPkg::opOri: begin
                entryState = ctrlPkg::logicImm3;
                aluControl = ctrlPkg::aluOrCode;
            end
            ctrlPkg::opNot, ctrlPkg::opNeg: entryState = ctrlPkg::aluReg3;
            ctrlPkg::opBranch: begin
                // PC plus offset
                entryState = ctrlPkg::branch3;
                aluControl = ctrlPkg::aluAddCode;
            end
            ctrlPkg::opJr, ctrlPkg::opJal: entryState = ctrlPkg::jump3;
            ctrlPkg::opMfhi: entryState = ctrlPkg::mfhi3;
            ctrlPkg::opMflo: entryState = ctrlPkg::mflo3;
            ctrlPkg::opHalt: entryState = ctrlPkg::halt3;
            // nop, dropped and unused codes refetch
            default: entryState = ctrlPkg::fetch0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/strobeGenerator.sv
`default_nettype none

module strobeGenerator (
    input  logic               clk,
    input  logic               reset,
    input  logic               CONFF,
    input  ctrlPkg::ctrlStateT state,
    output logic               PCout,
    output logic               PCin,
    output logic               IncPC,
    output logic               MARin,
    output logic               MDRin,
    output logic               MDRout,
    output logic               IRin,
    output logic               Yin,
    output logic               Zin,
    output logic               Zlowout,
    output logic               Read,
    output logic               Write,
    output logic               clear,
    output logic               run,
    output logic               Gra,
    output logic               Grb,
    output logic               Grc,
    output logic               Rin,
    output logic               Rout,
    output logic               BAout,
    output logic               Cout,
    output logic               ConIn,
    output logic               HIout,
    output logic               LOout
);

    logic branchTaken;

    // CONFF is valid at the end of branch3, once ConIn has loaded it
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            branchTaken <= 1'b0;
        end else if (state == ctrlPkg::branch3) begin
            branchTaken <= CONFF;
        end
    end

    always_comb begin
        PCout   = 1'b0;
        PCin    = 1'b0;
        IncPC   = 1'b0;
        MARin   = 1'b0;
        MDRin   = 1'b0;
        MDRout  = 1'b0;
        IRin    = 1'b0;
        Yin     = 1'b0;
        Zin     = 1'b0;
        Zlowout = 1'b0;
        Read    = 1'b0;
        Write   = 1'b0;
        clear   = 1'b0;
        run     = 1'b1;
        Gra     = 1'b0;
        Grb     = 1'b0;
        Grc     = 1'b0;
        Rin     = 1'b0;
        Rout    = 1'b0;
        BAout   = 1'b0;
        Cout    = 1'b0;
        ConIn   = 1'b0;
        HIout   = 1'b0;
        LOout   = 1'b0;
        case (state)
            ctrlPkg::stReset: clear = 1'b1;
            ctrlPkg::fetch0: begin
                PCout = 1'b1;
                MARin = 1'b1;
            end
            ctrlPkg::fetch1, ctrlPkg::load6: begin
                Read  = 1'b1;
                MDRin = 1'b1;
            end
            ctrlPkg::fetch2: begin
                MDRout = 1'b1;
                IRin   = 1'b1;
                IncPC  = 1'b1;
            end
            // rB into Y
            ctrlPkg::alu3, ctrlPkg::aluReg3, ctrlPkg::addi3,
            ctrlPkg::load3, ctrlPkg::loadi3: begin
                Grb   = 1'b1;
                BAout = 1'b1;
                Yin   = 1'b1;
            end
            ctrlPkg::logicImm3: begin
                Grb  = 1'b1;
                Rout = 1'b1;
                Yin  = 1'b1;
            end
            ctrlPkg::alu4: begin
                Grc   = 1'b1;
                BAout = 1'b1;
                Zin   = 1'b1;
            end
            ctrlPkg::aluReg4: Zin = 1'b1;
            // sign-extended constant from IR
            ctrlPkg::addi4, ctrlPkg::logicImm4, ctrlPkg::load4,
            ctrlPkg::loadi4, ctrlPkg::store4, ctrlPkg::branch5: begin
                Cout = 1'b1;
                Zin  = 1'b1;
            end
            ctrlPkg::alu5, ctrlPkg::aluReg5, ctrlPkg::addi5,
            ctrlPkg::logicImm5, ctrlPkg::loadi5: begin
                Zlowout = 1'b1;
                Gra     = 1'b1;
                Rin     = 1'b1;
            end
            ctrlPkg::load5, ctrlPkg::store5: begin
                Zlowout = 1'b1;
                MARin   = 1'b1;
            end
            ctrlPkg::load7: begin
                MDRout = 1'b1;
                Gra    = 1'b1;
                Rin    = 1'b1;
            end
            ctrlPkg::store3: begin
                Gra   = 1'b1;
                BAout = 1'b1;
                Yin   = 1'b1;
            end
            ctrlPkg::store6: begin
                Grb   = 1'b1;
                BAout = 1'b1;
                MDRin = 1'b1;
            end
            ctrlPkg::store7: Write = 1'b1;
            ctrlPkg::branch3: begin
                Gra   = 1'b1;
                Rout  = 1'b1;
                ConIn = 1'b1;
            end
            ctrlPkg::branch4: begin
                PCout = 1'b1;
                Yin   = 1'b1;
            end
            ctrlPkg::branch6: begin
                Zlowout = 1'b1;
                PCin    = branchTaken;
            end
            ctrlPkg::jump3: begin
                Gra   = 1'b1;
                Rout  = 1'b1;
                BAout = 1'b1;
                PCin  = 1'b1;
            end
            ctrlPkg::mfhi3: begin
                HIout = 1'b1;
                Gra   = 1'b1;
                Rin   = 1'b1;
            end
            ctrlPkg::mflo3: begin
                LOout = 1'b1;
                Gra   = 1'b1;
                Rin   = 1'b1;
            end
            ctrlPkg::halt3: run = 1'b0;
            // jump4, mfhi4, mflo4 are idle
            default: ;
        endcase
    end

    noReadWrite: assert property (@(posedge clk) disable iff (reset) !(Read && Write));

    pcLoadStates: assert property (@(posedge clk) disable iff (reset)
        PCin |-> (state == ctrlPkg::jump3 || state == ctrlPkg::branch6));

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the control unit testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module controlUnitTb -f flist.f -o controlUnitSim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/controlUnitSim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$SIM_LOG"; then
    exit 1
fi
exit 0

// File: tests/controlUnitTb.sv
`default_nettype none

module controlUnitTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clkPeriod = 20;
    localparam int resetCycles = 8;
    localparam int timeoutCycles = 50;
    localparam int fieldCount = 9;
    localparam int goldenDepth = 32 * fieldCount;
    localparam logic [31:0] seed = 32'h9742_67e1;

    logic clk;
    logic reset;
    logic [ctrlPkg::instrWidth-1:0] IR;
    logic CONFF;
    logic PCout, PCin, IncPC, MARin, MDRin, MDRout, IRin, Yin, Zin, Zlowout;
    logic Read, Write, clear, run, Gra, Grb, Grc, Rin, Rout, BAout, Cout, ConIn;
    logic HIout, LOout;
    logic [ctrlPkg::opcodeWidth-1:0] aluControl;
    logic [21:0] busStrobes;

    logic [7:0] golden [0:goldenDepth-1];
    int errors;
    int timeouts;
    int idx;

    controlUnit dut_i (
        .clk(clk), .reset(reset), .IR(IR), .CONFF(CONFF),
        .PCout(PCout), .PCin(PCin), .IncPC(IncPC), .MARin(MARin), .MDRin(MDRin),
        .MDRout(MDRout), .IRin(IRin), .Yin(Yin), .Zin(Zin), .Zlowout(Zlowout),
        .Read(Read), .Write(Write), .clear(clear), .run(run), .Gra(Gra), .Grb(Grb),
        .Grc(Grc), .Rin(Rin), .Rout(Rout), .BAout(BAout), .Cout(Cout), .ConIn(ConIn),
        .HIout(HIout), .LOout(LOout), .aluControl(aluControl)
    );

    // everything except clear and run
    assign busStrobes = {PCout, PCin, IncPC, MARin, MDRin, MDRout, IRin, Yin, Zin,
                         Zlowout, Read, Write, Gra, Grb, Grc, Rin, Rout, BAout, Cout,
                         ConIn, HIout, LOout};

    always #(clkPeriod / 2) clk = ~clk;

    task automatic checkEq(input int actual, input int expected, input string msg);
        if (actual != expected) begin
            $display("CHECK FAILED at %0t: %s (got %0d, expected %0d)",
                     $time, msg, actual, expected);
            errors++;
        end
    endtask

    task automatic waitForFetch();
        int steps;
        steps = 0;
        while (!(PCout && MARin) && steps < timeoutCycles) begin
            @(posedge clk);
            #2;
            steps++;
        end
        if (!(PCout && MARin)) begin
            $display("timeout: fetch0 did not appear within %0d cycles", timeoutCycles);
            timeouts++;
        end
    endtask

    task automatic applyReset();
        reset = 1'b1;
        repeat (resetCycles) begin
            @(posedge clk);
            #2;
            checkEq(int'(clear), 1, "clear during reset");
            checkEq(int'(run), 1, "run during reset");
            checkEq(int'(busStrobes), 0, "other strobes during reset");
        end
        reset = 1'b0;
        @(posedge clk);
        #2;
        checkEq(int'(PCout && MARin), 1, "fetch0 one cycle after reset release");
        if (!(PCout && MARin)) begin
            waitForFetch();
        end
    endtask

    // halt must hold until the next reset
    task automatic confirmHalted();
        repeat (timeoutCycles) begin
            @(posedge clk);
            #2;
            checkEq(int'(run), 0, "run stays low after halt");
            checkEq(int'(PCout && MARin), 0, "no fetch0 after halt");
        end
    endtask

    // entered while fetch0 is showing, returns at the next fetch0
    task automatic runInstruction(input int line);
        int base;
        int cycles;
        int steps;
        int reads;
        int writes;
        int pcLoads;
        int regWrites;
        int aluSeen;
        int halted;
        int done;
        string tag;
        base = line * fieldCount;
        cycles = 1;
        steps = 0;
        reads = 0;
        writes = 0;
        pcLoads = 0;
        regWrites = 0;
        aluSeen = -1;
        halted = 0;
        done = 0;
        tag = $sformatf("line %0d op %02h", line, golden[base]);
        IR = {golden[base][4:0], 27'($urandom())};
        CONFF = golden[base + 1][0];
        while (done == 0 && steps < timeoutCycles) begin
            @(posedge clk);
            #2;
            steps++;
            if (!run) begin
                halted = 1;
                done = 1;
            end else if (PCout && MARin) begin
                done = 1;
            end else begin
                cycles++;
                if (Read) reads++;
                if (Write) writes++;
                if (PCin) pcLoads++;
                if (Rin) regWrites++;
                if (IRin) aluSeen = int'(aluControl);
            end
        end
        if (done == 0) begin
            $display("timeout: %s never returned to fetch0 or halted", tag);
            timeouts++;
        end else begin
            checkEq(cycles, int'(golden[base + 2]), {tag, " cycles"});
            checkEq(aluSeen, int'(golden[base + 3]), {tag, " aluControl"});
            checkEq(writes, int'(golden[base + 4]), {tag, " Write count"});
            checkEq(pcLoads, int'(golden[base + 5]), {tag, " PCin count"});
            checkEq(regWrites, int'(golden[base + 6]), {tag, " Rin count"});
            checkEq(reads, int'(golden[base + 7]), {tag, " Read count"});
            checkEq(halted, int'(golden[base + 8]), {tag, " halt flag"});
            if (halted != 0) begin
                confirmHalted();
                applyReset();
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        IR = '0;
        CONFF = 1'b0;
        errors = 0;
        timeouts = 0;
        void'($urandom(seed));
        for (int i = 0; i < goldenDepth; i++) begin
            golden[i] = 8'hff;
        end
        $readmemh("tests/controlUnit_golden.txt", golden);
        applyReset();
        idx = 0;
        while (golden[idx * fieldCount] != 8'hff && timeouts == 0) begin
            runInstruction(idx);
            idx++;
        end
        $display("%0d instructions, %0d check failures, %0d timeouts",
                 idx, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/controlUnit_golden.txt
// opcode conff cycles aluControl writeCount pcinCount rinCount readCount halt
// all hex; cycles run from fetch0 to the next fetch0, or to run low for halt
00 00 08 03 00 00 01 02 00
01 00 06 03 00 00 01 01 00
02 00 08 03 01 00 00 01 00
03 00 06 03 00 00 01 01 00
04 01 06 04 00 00 01 01 00
09 00 06 09 00 00 01 01 00
0a 00 06 0a 00 00 01 01 00
0b 00 06 03 00 00 01 01 00
0c 00 06 09 00 00 01 01 00
0d 01 06 0a 00 00 01 01 00
10 00 06 10 00 00 01 01 00
11 00 06 11 00 00 01 01 00
12 01 07 03 00 01 00 01 00
12 00 07 03 00 00 00 01 00
13 00 05 13 00 01 00 01 00
14 01 05 14 00 01 00 01 00
17 00 05 17 00 00 01 01 00
18 00 05 18 00 00 01 01 00
19 00 03 19 00 00 00 01 00
0e 00 03 0e 00 00 00 01 00
1b 00 03 1b 00 00 00 01 01
1f 01 03 1f 00 00 00 01 00
12 01 07 03 00 01 00 01 00
02 00 08 03 01 00 00 01 00
